//--- common/vm_pkg.sv
// Shared widths, operation and exception encodings, and page-table types for the VM unit
package vm_pkg;

  localparam int VADDR_W    = 20;
  localparam int PAGE_OFF_W = 8;
  localparam int VPN_W      = 6;
  localparam int VTAG_W     = 2 * VPN_W;
  localparam int PPN_W      = 6;
  localparam int PADDR_W    = PPN_W + PAGE_OFF_W;
  localparam int WORD_W     = 32;
  // Word address on the memory port
  localparam int WADDR_W    = PADDR_W - 2;

  typedef enum logic [1:0] {
    e_priv_u = 2'd0,
    e_priv_s = 2'd1,
    e_priv_m = 2'd3
  } priv_e;

  typedef enum logic [1:0] {
    e_op_load,
    e_op_store,
    e_op_tlb_flush
  } mem_op_e;

  typedef enum logic [2:0] {
    e_exc_none,
    e_exc_load_page_fault,
    e_exc_store_page_fault,
    e_exc_load_access_fault,
    e_exc_store_access_fault
  } exc_e;

  // Read and write both clear means pointer to next level
  typedef struct packed {
    logic                      valid;
    logic                      read;
    logic                      write;
    logic                      user;
    logic                      dirty;
    logic [WORD_W-6-PPN_W:0]   rsvd;
    logic [PPN_W-1:0]          ppn;
  } pte_t;

  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic             write;
    logic             user;
    logic             dirty;
  } tlb_entry_t;

endpackage

//--- common/dmem_if.sv
`timescale 1ns/1ns
// Word-wide data memory port between a requester and the RAM
interface dmem_if import vm_pkg::*; ();

  logic               req_v;
  logic               we;
  logic [WADDR_W-1:0] addr;
  logic [WORD_W-1:0]  wdata;
  // Valid the cycle after a read request
  logic [WORD_W-1:0]  rdata;

  modport requester (
    output req_v,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport memory (
    input  req_v,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

//--- dtlb/dtlb.sv
`timescale 1ns/1ns
// Fully associative data TLB with registered lookup, round-robin fill and flush
module dtlb import vm_pkg::*; #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              lookup_v_i,
  input  logic              flush_i,
  input  logic [VTAG_W-1:0] vtag_i,
  input  logic              fill_v_i,
  input  logic [VTAG_W-1:0] fill_vtag_i,
  input  tlb_entry_t        fill_entry_i,
  output logic              hit_o,
  output logic              miss_o,
  output tlb_entry_t        entry_o
);

  localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0] valid_r;
  logic [VTAG_W-1:0]      vtag_r  [TLB_ENTRIES];
  tlb_entry_t             entry_r [TLB_ENTRIES];
  logic [IDX_W-1:0]       victim_r;
  logic                   match;
  tlb_entry_t             match_entry;

  always_comb begin
    match       = 1'b0;
    match_entry = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (valid_r[i] && (vtag_r[i] == vtag_i)) begin
        match       = 1'b1;
        match_entry = entry_r[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
      hit_o    <= 1'b0;
      miss_o   <= 1'b0;
    end else begin
      // Lookup racing a flush sees an empty TLB
      hit_o  <= lookup_v_i && match && !flush_i;
      miss_o <= lookup_v_i && !(match && !flush_i);
      if (flush_i) begin
        valid_r <= '0;
      end else if (fill_v_i) begin
        valid_r[victim_r] <= 1'b1;
        victim_r <= (victim_r == IDX_W'(TLB_ENTRIES - 1)) ? '0 : victim_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      vtag_r[victim_r]  <= fill_vtag_i;
      entry_r[victim_r] <= fill_entry_i;
    end
    entry_o <= match_entry;
  end

  // Fills only happen while the walker holds off new commands
  a_no_fill_lookup: assert property (@(posedge clk_i) disable iff (reset_i)
    !(fill_v_i && lookup_v_i));

endmodule

//--- ptw/page_walker.sv
`timescale 1ns/1ns
// Two-level page table walker reading entries through the shared memory port
module page_walker import vm_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              start_i,
  input  logic              store_i,
  input  logic [VTAG_W-1:0] vtag_i,
  input  logic [PPN_W-1:0]  root_ppn_i,
  output logic              busy_o,
  output logic              fault_o,
  output logic              fault_store_o,
  output logic              fill_v_o,
  output logic [VTAG_W-1:0] fill_vtag_o,
  output tlb_entry_t        fill_entry_o,
  dmem_if.requester         mem
);

  typedef enum logic [2:0] {
    e_walk_idle,
    e_walk_rd1,
    e_walk_wait1,
    e_walk_rd2,
    e_walk_wait2,
    e_walk_fill
  } walk_state_e;

  walk_state_e       state_r;
  logic [VTAG_W-1:0] vtag_r;
  logic              store_r;
  logic [PPN_W-1:0]  table_ppn_r;
  tlb_entry_t        leaf_r;
  pte_t              pte;
  logic              l1_bad;
  logic              l2_bad;

  assign pte = pte_t'(mem.rdata);
  // No superpages, level 1 must point onward and level 2 must be a leaf
  assign l1_bad = !pte.valid || pte.read || pte.write;
  assign l2_bad = !pte.valid || (!pte.read && !pte.write);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_walk_idle;
    end else begin
      case (state_r)
        e_walk_idle: begin
          if (start_i) begin
            state_r <= e_walk_rd1;
          end
        end
        e_walk_rd1:   state_r <= e_walk_wait1;
        e_walk_wait1: state_r <= l1_bad ? e_walk_idle : e_walk_rd2;
        e_walk_rd2:   state_r <= e_walk_wait2;
        e_walk_wait2: state_r <= l2_bad ? e_walk_idle : e_walk_fill;
        default:      state_r <= e_walk_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == e_walk_idle) && start_i) begin
      vtag_r  <= vtag_i;
      store_r <= store_i;
    end
    if (state_r == e_walk_wait1) begin
      table_ppn_r <= pte.ppn;
    end
    if (state_r == e_walk_wait2) begin
      leaf_r <= '{ppn: pte.ppn, write: pte.write, user: pte.user, dirty: pte.dirty};
    end
  end

  // Entry word address is table page plus level index
  assign mem.req_v = (state_r == e_walk_rd1) || (state_r == e_walk_rd2);
  assign mem.we    = 1'b0;
  assign mem.wdata = '0;
  assign mem.addr  = (state_r == e_walk_rd1) ? {root_ppn_i, vtag_r[VTAG_W-1:VPN_W]}
                                             : {table_ppn_r, vtag_r[VPN_W-1:0]};

  assign busy_o        = (state_r != e_walk_idle);
  assign fault_o       = ((state_r == e_walk_wait1) && l1_bad)
                       || ((state_r == e_walk_wait2) && l2_bad);
  assign fault_store_o = store_r;
  assign fill_v_o      = (state_r == e_walk_fill);
  assign fill_vtag_o   = vtag_r;
  assign fill_entry_o  = leaf_r;

endmodule

//--- hdl/perm_check.sv
`timescale 1ns/1ns
// Page and access fault decision for one data access
module perm_check import vm_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic             chk_v_i,
  input  logic             store_i,
  input  logic             translated_i,
  input  logic [PPN_W-1:0] ppn_i,
  input  tlb_entry_t       entry_i,
  input  priv_e            priv_mode_i,
  input  logic             sum_i,
  output exc_e             exc_o
);

  localparam int IMPL_PAGES = MEM_WORDS * 4 / (2 ** PAGE_OFF_W);

  logic priv_fault;
  logic write_fault;
  logic page_fault;
  logic access_fault;

  always_comb begin
    priv_fault   = ((priv_mode_i == e_priv_s) && !sum_i && entry_i.user)
                 || ((priv_mode_i == e_priv_u) && !entry_i.user);
    write_fault  = store_i && (!entry_i.write || !entry_i.dirty);
    page_fault   = translated_i && (priv_fault || write_fault);
    // Pages past the RAM also fault in bare mode
    access_fault = (int'(ppn_i) >= IMPL_PAGES);
    exc_o = e_exc_none;
    if (chk_v_i && page_fault) begin
      exc_o = store_i ? e_exc_store_page_fault : e_exc_load_page_fault;
    end else if (chk_v_i && access_fault) begin
      exc_o = store_i ? e_exc_store_access_fault : e_exc_load_access_fault;
    end
  end

endmodule

//--- hdl/data_ram.sv
`timescale 1ns/1ns
// Word-addressed synchronous data memory with registered read
module data_ram import vm_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic   clk_i,
  dmem_if.memory mem
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [WORD_W-1:0] ram_r [MEM_WORDS];
  logic [IDX_W-1:0]  idx;

  assign idx = mem.addr[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (mem.req_v) begin
      if (mem.we) begin
        ram_r[idx] <= mem.wdata;
      end else begin
        mem.rdata <= ram_r[idx];
      end
    end
  end

  // Callers filter unimplemented pages before they reach the RAM
  a_addr_range: assert property (@(posedge clk_i)
    mem.req_v |-> (mem.addr < MEM_WORDS));

endmodule

//--- hdl/mem_pipe_ctrl.sv
`timescale 1ns/1ns
// Two-stage command pipeline with RAM port arbitration, response forming and kill
module mem_pipe_ctrl import vm_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               translation_en_i,
  input  logic               cmd_v_i,
  input  mem_op_e            cmd_op_i,
  input  logic [VADDR_W-1:0] cmd_vaddr_i,
  input  logic [WORD_W-1:0]  cmd_data_i,
  input  logic               kill_i,
  output logic               cmd_ready_o,
  output logic               resp_v_o,
  output logic               resp_miss_o,
  output exc_e               resp_exc_o,
  output logic [WORD_W-1:0]  resp_data_o,
  output logic               tlb_lookup_v_o,
  output logic               tlb_flush_o,
  output logic [VTAG_W-1:0]  tlb_vtag_o,
  input  logic               tlb_hit_i,
  input  logic               tlb_miss_i,
  input  tlb_entry_t         tlb_entry_i,
  output logic               chk_v_o,
  output logic               chk_store_o,
  output logic [PPN_W-1:0]   chk_ppn_o,
  input  exc_e               chk_exc_i,
  output logic               walk_start_o,
  output logic               walk_store_o,
  output logic [VTAG_W-1:0]  walk_vtag_o,
  input  logic               walk_busy_i,
  input  logic               walk_fault_i,
  input  logic               walk_fault_store_i,
  dmem_if.memory             walk_mem,
  dmem_if.requester          ram_port
);

  logic               accept;
  logic               s1_v_r;
  mem_op_e            s1_op_r;
  logic [VADDR_W-1:0] s1_vaddr_r;
  logic [WORD_W-1:0]  s1_data_r;
  logic               s1_mem;
  logic               s1_miss;
  logic               s1_go;
  logic [PPN_W-1:0]   s1_ppn;
  logic               s2_v_r;
  logic               s2_miss_r;
  exc_e               s2_exc_r;
  logic               s2_store_r;
  logic [VTAG_W-1:0]  s2_vtag_r;

  assign accept         = cmd_v_i && cmd_ready_o;
  assign tlb_lookup_v_o = accept && translation_en_i && (cmd_op_i != e_op_tlb_flush);
  assign tlb_vtag_o     = cmd_vaddr_i[VADDR_W-1:PAGE_OFF_W];

  assign s1_mem      = s1_v_r && (s1_op_r != e_op_tlb_flush);
  assign s1_miss     = s1_mem && translation_en_i && tlb_miss_i;
  assign tlb_flush_o = s1_v_r && (s1_op_r == e_op_tlb_flush) && !kill_i;

  // Bare mode keeps only the implemented physical address bits
  assign s1_ppn      = translation_en_i ? tlb_entry_i.ppn : s1_vaddr_r[PADDR_W-1:PAGE_OFF_W];
  assign chk_v_o     = s1_mem && (tlb_hit_i || !translation_en_i);
  assign chk_store_o = (s1_op_r == e_op_store);
  assign chk_ppn_o   = s1_ppn;
  // A store must also survive the kill window
  assign s1_go = chk_v_o && (chk_exc_i == e_exc_none) && !(chk_store_o && kill_i);

  // Walker owns the RAM port for the whole walk
  always_comb begin
    if (walk_busy_i) begin
      ram_port.req_v = walk_mem.req_v;
      ram_port.we    = walk_mem.we;
      ram_port.addr  = walk_mem.addr;
      ram_port.wdata = walk_mem.wdata;
    end else begin
      ram_port.req_v = s1_go;
      ram_port.we    = chk_store_o;
      ram_port.addr  = {s1_ppn, s1_vaddr_r[PAGE_OFF_W-1:2]};
      ram_port.wdata = s1_data_r;
    end
  end
  assign walk_mem.rdata = ram_port.rdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
      s2_v_r <= 1'b0;
    end else begin
      s1_v_r <= accept;
      s2_v_r <= s1_v_r && !kill_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      s1_op_r    <= cmd_op_i;
      s1_vaddr_r <= cmd_vaddr_i;
      s1_data_r  <= cmd_data_i;
    end
    if (s1_v_r) begin
      s2_miss_r  <= s1_miss;
      s2_exc_r   <= chk_exc_i;
      s2_store_r <= chk_store_o;
      s2_vtag_r  <= s1_vaddr_r[VADDR_W-1:PAGE_OFF_W];
    end
  end

  // Miss response and walk start share cycle 2
  assign walk_start_o = s2_v_r && s2_miss_r;
  assign walk_store_o = s2_store_r;
  assign walk_vtag_o  = s2_vtag_r;

  assign cmd_ready_o = !walk_busy_i && !s1_miss && !walk_start_o;
  assign resp_v_o    = s2_v_r || walk_fault_i;
  assign resp_miss_o = s2_v_r && s2_miss_r;
  assign resp_data_o = ram_port.rdata;

  always_comb begin
    if (walk_fault_i) begin
      resp_exc_o = walk_fault_store_i ? e_exc_store_page_fault : e_exc_load_page_fault;
    end else begin
      resp_exc_o = s2_exc_r;
    end
  end

  // Only the walker's own fault may answer while it runs
  a_walk_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    (walk_busy_i && resp_v_o) |->
      (resp_exc_o inside {e_exc_load_page_fault, e_exc_store_page_fault}));

endmodule

//--- hdl/vm_mem_top.sv
`timescale 1ns/1ns
// VM data-side top, joins command control, data TLB, walker, permission check and RAM
module vm_mem_top import vm_pkg::*; #(
  parameter int TLB_ENTRIES = 4,
  parameter int MEM_WORDS   = 1024
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               translation_en_i,
  input  priv_e              priv_mode_i,
  input  logic               sum_i,
  input  logic [PPN_W-1:0]   root_ppn_i,
  input  logic               cmd_v_i,
  input  mem_op_e            cmd_op_i,
  input  logic [VADDR_W-1:0] cmd_vaddr_i,
  input  logic [WORD_W-1:0]  cmd_data_i,
  input  logic               kill_i,
  output logic               cmd_ready_o,
  output logic               resp_v_o,
  output logic               resp_miss_o,
  output exc_e               resp_exc_o,
  output logic [WORD_W-1:0]  resp_data_o
);

  logic              tlb_lookup_v;
  logic              tlb_flush;
  logic [VTAG_W-1:0] tlb_vtag;
  logic              tlb_hit;
  logic              tlb_miss;
  tlb_entry_t        tlb_entry;
  logic              chk_v;
  logic              chk_store;
  logic [PPN_W-1:0]  chk_ppn;
  exc_e              chk_exc;
  logic              walk_start;
  logic              walk_store;
  logic [VTAG_W-1:0] walk_vtag;
  logic              walk_busy;
  logic              walk_fault;
  logic              walk_fault_store;
  logic              fill_v;
  logic [VTAG_W-1:0] fill_vtag;
  tlb_entry_t        fill_entry;

  dmem_if walk_mem ();
  dmem_if ram_port ();

  mem_pipe_ctrl u_ctrl (
    .clk_i, .reset_i, .translation_en_i,
    .cmd_v_i, .cmd_op_i, .cmd_vaddr_i, .cmd_data_i, .kill_i,
    .cmd_ready_o, .resp_v_o, .resp_miss_o, .resp_exc_o, .resp_data_o,
    .tlb_lookup_v_o(tlb_lookup_v), .tlb_flush_o(tlb_flush), .tlb_vtag_o(tlb_vtag),
    .tlb_hit_i(tlb_hit), .tlb_miss_i(tlb_miss), .tlb_entry_i(tlb_entry),
    .chk_v_o(chk_v), .chk_store_o(chk_store), .chk_ppn_o(chk_ppn), .chk_exc_i(chk_exc),
    .walk_start_o(walk_start), .walk_store_o(walk_store), .walk_vtag_o(walk_vtag),
    .walk_busy_i(walk_busy), .walk_fault_i(walk_fault), .walk_fault_store_i(walk_fault_store),
    .walk_mem(walk_mem.memory), .ram_port(ram_port.requester)
  );

  dtlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_dtlb (
    .clk_i, .reset_i,
    .lookup_v_i(tlb_lookup_v), .flush_i(tlb_flush), .vtag_i(tlb_vtag),
    .fill_v_i(fill_v), .fill_vtag_i(fill_vtag), .fill_entry_i(fill_entry),
    .hit_o(tlb_hit), .miss_o(tlb_miss), .entry_o(tlb_entry)
  );

  page_walker u_walker (
    .clk_i, .reset_i,
    .start_i(walk_start), .store_i(walk_store), .vtag_i(walk_vtag), .root_ppn_i,
    .busy_o(walk_busy), .fault_o(walk_fault), .fault_store_o(walk_fault_store),
    .fill_v_o(fill_v), .fill_vtag_o(fill_vtag), .fill_entry_o(fill_entry),
    .mem(walk_mem.requester)
  );

  perm_check #(.MEM_WORDS(MEM_WORDS)) u_perm (
    .chk_v_i(chk_v), .store_i(chk_store), .translated_i(translation_en_i),
    .ppn_i(chk_ppn), .entry_i(tlb_entry), .priv_mode_i, .sum_i, .exc_o(chk_exc)
  );

  data_ram #(.MEM_WORDS(MEM_WORDS)) u_ram (
    .clk_i, .mem(ram_port.memory)
  );

endmodule

//--- tests/tb_vm_mem_top.sv
`timescale 1ns/1ns
// Testbench for the VM data unit with a reference translation and mirror memory
module tb_vm_mem_top import vm_pkg::*; ();

  localparam int TLB_ENTRIES = 4;
  localparam int MEM_WORDS   = 1024;
  localparam int IMPL_PAGES  = MEM_WORDS * 4 / 256;
  localparam int TIMEOUT_CYC = 100;

  typedef struct packed {
    logic        walk_fault;
    exc_e        exc;
    logic [11:0] waddr;
    logic [31:0] data;
  } ref_t;

  // late marks a walk-fault answer, which comes when the walk ends
  typedef struct packed {
    logic [31:0] due;
    logic        late;
    logic        miss;
    exc_e        exc;
    logic        chk_data;
    logic [31:0] data;
  } exp_t;

  logic               clk_i = 1'b0;
  logic               reset_i;
  logic               translation_en_i;
  priv_e              priv_mode_i;
  logic               sum_i;
  logic [PPN_W-1:0]   root_ppn_i;
  logic               cmd_v_i;
  mem_op_e            cmd_op_i;
  logic [VADDR_W-1:0] cmd_vaddr_i;
  logic [WORD_W-1:0]  cmd_data_i;
  logic               kill_i;
  logic               cmd_ready_o;
  logic               resp_v_o;
  logic               resp_miss_o;
  exc_e               resp_exc_o;
  logic [WORD_W-1:0]  resp_data_o;

  logic [WORD_W-1:0]  mirror [MEM_WORDS];
  logic [VTAG_W-1:0]  tlb_q [$];
  exp_t               exp_q [$];
  logic [31:0]        cyc = '0;
  logic [31:0]        lfsr_q = 32'h533e;
  int                 mismatch_cnt = 0;
  int                 fail_cnt = 0;
  logic               aborted = 1'b0;

  vm_mem_top #(.TLB_ENTRIES(TLB_ENTRIES), .MEM_WORDS(MEM_WORDS)) u_dut (.*);

  always #5 clk_i = ~clk_i;

  // Counted on the rising edge so falling-edge samplers read a settled value
  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] make_pte(input logic v, input logic r, input logic w,
                                           input logic u, input logic d, input logic [5:0] ppn);
    pte_t p;
    p = '0;
    p.valid = v;
    p.read  = r;
    p.write = w;
    p.user  = u;
    p.dirty = d;
    p.ppn   = ppn;
    return p;
  endfunction

  function automatic logic [VADDR_W-1:0] va_of(input logic [5:0] v1, input logic [5:0] v0,
                                               input logic [7:0] off);
    return {v1, v0, off};
  endfunction

  function automatic logic tlb_has(input logic [VTAG_W-1:0] vtag);
    logic found;
    found = 1'b0;
    foreach (tlb_q[i]) begin
      if (tlb_q[i] == vtag) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // Expected outcome of one access under the current mode and mirror contents
  function automatic ref_t ref_access(input mem_op_e op, input logic [VADDR_W-1:0] va);
    ref_t        r;
    pte_t        l1;
    pte_t        l2;
    logic        store;
    logic        pf;
    logic [5:0]  ppn;
    store = (op == e_op_store);
    r = '0;
    pf = 1'b0;
    ppn = va[13:8];
    if (translation_en_i) begin
      l1 = pte_t'(mirror[{root_ppn_i, va[19:14]}]);
      if (!l1.valid || l1.read || l1.write) begin
        r.walk_fault = 1'b1;
      end else begin
        l2 = pte_t'(mirror[{l1.ppn, va[13:8]}]);
        if (!l2.valid || (!l2.read && !l2.write)) begin
          r.walk_fault = 1'b1;
        end else begin
          ppn = l2.ppn;
          pf = ((priv_mode_i == e_priv_s) && !sum_i && l2.user)
             || ((priv_mode_i == e_priv_u) && !l2.user)
             || (store && (!l2.write || !l2.dirty));
        end
      end
    end
    r.waddr = {ppn, va[7:2]};
    if (r.walk_fault || pf) begin
      r.exc = store ? e_exc_store_page_fault : e_exc_load_page_fault;
    end else if (int'(ppn) >= IMPL_PAGES) begin
      r.exc = store ? e_exc_store_access_fault : e_exc_load_access_fault;
    end else if (!store) begin
      r.data = mirror[r.waddr];
    end
    return r;
  endfunction

  task automatic check_exc(input string name, input exc_e got, input exc_e exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_data(input string name, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_miss(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  always @(negedge clk_i) begin : resp_monitor
    exp_t e;
    if (!reset_i) begin
      if (resp_v_o) begin
        if (exp_q.size() == 0) begin
          fail_cnt++;
          $display("error at %0t: response with no command pending", $time);
        end else begin
          e = exp_q.pop_front();
          if (!e.late && (e.due != cyc)) begin
            fail_cnt++;
            $display("error at %0t: response in cycle %0d, expected in cycle %0d",
                     $time, cyc, e.due);
          end
          check_miss("resp_miss_o", resp_miss_o, e.miss);
          check_exc("resp_exc_o", resp_exc_o, e.exc);
          if (e.chk_data) begin
            check_data("resp_data_o", resp_data_o, e.data);
          end
        end
      end else if ((exp_q.size() > 0) && !exp_q[0].late && (exp_q[0].due <= cyc)) begin
        fail_cnt++;
        $display("error at %0t: no response for command due in cycle %0d", $time, exp_q[0].due);
        void'(exp_q.pop_front());
      end
    end
  end

  // Entered and left 1 ns after a rising edge
  task automatic issue(input mem_op_e op, input logic [VADDR_W-1:0] va,
                       input logic [WORD_W-1:0] wd, input logic kill, output logic missed);
    ref_t        r;
    exp_t        e;
    logic        rdy;
    int          waits;
    logic [31:0] acc_cyc;
    missed = 1'b0;
    if (!aborted) begin
      cmd_v_i     = 1'b1;
      cmd_op_i    = op;
      cmd_vaddr_i = va;
      cmd_data_i  = wd;
      rdy = 1'b0;
      waits = 0;
      while (!rdy && (waits < TIMEOUT_CYC)) begin
        @(negedge clk_i);
        rdy = cmd_ready_o;
        waits++;
      end
      acc_cyc = cyc;
      @(posedge clk_i);
      #1;
      cmd_v_i = 1'b0;
      if (!rdy) begin
        fail_cnt++;
        $display("error at %0t: command never accepted, cmd_ready_o stayed low", $time);
        aborted = 1'b1;
      end else begin
        if (kill) begin
          kill_i = 1'b1;
        end
        e = '0;
        e.due = acc_cyc + 2;
        if (op == e_op_tlb_flush) begin
          if (!kill) begin
            tlb_q.delete();
            exp_q.push_back(e);
          end
        end else begin
          r = ref_access(op, va);
          missed = translation_en_i && !tlb_has(va[19:8]);
          if (kill) begin
            missed = 1'b0;
          end else if (missed) begin
            e.miss = 1'b1;
            exp_q.push_back(e);
            if (r.walk_fault) begin
              e.late = 1'b1;
              e.miss = 1'b0;
              e.exc  = r.exc;
              exp_q.push_back(e);
            end else begin
              tlb_q.push_back(va[19:8]);
              if (tlb_q.size() > TLB_ENTRIES) begin
                void'(tlb_q.pop_front());
              end
            end
          end else begin
            e.exc      = r.exc;
            e.chk_data = (op == e_op_load) && (r.exc == e_exc_none);
            e.data     = r.data;
            exp_q.push_back(e);
            if ((op == e_op_store) && (r.exc == e_exc_none)) begin
              mirror[r.waddr] = wd;
            end
          end
        end
        if (kill) begin
          @(posedge clk_i);
          #1;
          kill_i = 1'b0;
        end
      end
    end
  endtask

  // Replays once after a miss, as the core would
  task automatic access(input mem_op_e op, input logic [VADDR_W-1:0] va,
                        input logic [WORD_W-1:0] wd);
    logic missed;
    issue(op, va, wd, 1'b0, missed);
    if (missed) begin
      issue(op, va, wd, 1'b0, missed);
    end
  endtask

  task automatic poke(input logic [11:0] waddr, input logic [WORD_W-1:0] wd);
    logic missed;
    issue(e_op_store, {6'h0, waddr, 2'b00}, wd, 1'b0, missed);
  endtask

  task automatic drain();
    int   waits;
    logic idle;
    if (!aborted) begin
      idle = 1'b0;
      waits = 0;
      while (!idle && (waits < TIMEOUT_CYC)) begin
        @(posedge clk_i);
        #1;
        idle = (exp_q.size() == 0) && cmd_ready_o;
        waits++;
      end
      if (!idle) begin
        fail_cnt++;
        $display("error at %0t: responses still outstanding or walk never ended", $time);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic set_mode(input logic en, input priv_e priv, input logic sum);
    drain();
    translation_en_i = en;
    priv_mode_i      = priv;
    sum_i            = sum;
  endtask

  initial begin
    logic        missed;
    logic [11:0] addr_q [8];
    reset_i          = 1'b1;
    translation_en_i = 1'b0;
    priv_mode_i      = e_priv_m;
    sum_i            = 1'b0;
    root_ppn_i       = 6'd1;
    cmd_v_i          = 1'b0;
    cmd_op_i         = e_op_load;
    cmd_vaddr_i      = '0;
    cmd_data_i       = '0;
    kill_i           = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    if (!cmd_ready_o || resp_v_o) begin
      fail_cnt++;
      $display("error at %0t: unit not idle and ready after reset", $time);
    end

    // Bare mode, back to back into pages 8 to 15
    for (int i = 0; i < 8; i++) begin
      addr_q[i] = 12'h200 | 12'(rand_bits(9));
      poke(addr_q[i], rand_bits(32));
    end
    for (int i = 0; i < 8; i++) begin
      issue(e_op_load, {6'h0, addr_q[i], 2'b00}, '0, 1'b0, missed);
    end
    poke(12'h2f0, rand_bits(32));
    issue(e_op_load, {6'h0, 12'h2f0, 2'b00}, '0, 1'b0, missed);

    // Root table in page 1, level-2 table in page 2
    poke(12'd67, make_pte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd2));
    poke(12'd69, 32'h0);
    poke(12'd128, make_pte(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 6'd4));
    poke(12'd129, make_pte(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 6'd5));
    poke(12'd130, make_pte(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 6'd6));
    poke(12'd131, make_pte(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 6'd20));
    poke(12'd132, 32'h0);
    poke({6'd4, 6'd4}, rand_bits(32));
    poke({6'd5, 6'd4}, rand_bits(32));
    poke({6'd6, 6'd4}, rand_bits(32));

    set_mode(1'b1, e_priv_s, 1'b0);
    access(e_op_load, va_of(6'd3, 6'd1, 8'h10), '0);
    access(e_op_store, va_of(6'd3, 6'd1, 8'h20), rand_bits(32));
    access(e_op_load, va_of(6'd3, 6'd1, 8'h20), '0);

    // User page from supervisor, then a read-only page
    access(e_op_load, va_of(6'd3, 6'd0, 8'h10), '0);
    access(e_op_store, va_of(6'd3, 6'd2, 8'h10), rand_bits(32));
    access(e_op_load, va_of(6'd3, 6'd2, 8'h10), '0);
    set_mode(1'b1, e_priv_u, 1'b0);
    access(e_op_load, va_of(6'd3, 6'd0, 8'h10), '0);
    access(e_op_load, va_of(6'd3, 6'd1, 8'h10), '0);
    set_mode(1'b1, e_priv_s, 1'b1);
    access(e_op_load, va_of(6'd3, 6'd0, 8'h10), '0);

    // Invalid level-1 entry, then invalid level-2 entry
    access(e_op_load, va_of(6'd5, 6'd0, 8'h00), '0);
    access(e_op_store, va_of(6'd3, 6'd4, 8'h00), rand_bits(32));

    // Leaf pointing past the RAM
    access(e_op_load, va_of(6'd3, 6'd3, 8'h00), '0);
    access(e_op_store, va_of(6'd3, 6'd3, 8'h00), rand_bits(32));

    access(e_op_load, va_of(6'd3, 6'd1, 8'h10), '0);
    issue(e_op_tlb_flush, '0, '0, 1'b0, missed);
    access(e_op_load, va_of(6'd3, 6'd1, 8'h10), '0);

    set_mode(1'b0, e_priv_m, 1'b0);
    issue(e_op_load, {6'h0, 6'd40, 8'h00}, '0, 1'b0, missed);
    issue(e_op_store, {6'h0, 6'd40, 8'h00}, rand_bits(32), 1'b0, missed);
    poke(12'h300, rand_bits(32));
    issue(e_op_store, {6'h0, 12'h300, 2'b00}, rand_bits(32), 1'b1, missed);
    issue(e_op_load, {6'h0, 12'h300, 2'b00}, '0, 1'b0, missed);

    drain();
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if ((mismatch_cnt == 0) && (fail_cnt == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
common/vm_pkg.sv
common/dmem_if.sv
dtlb/dtlb.sv
ptw/page_walker.sv
hdl/perm_check.sv
hdl/data_ram.sv
hdl/mem_pipe_ctrl.sv
hdl/vm_mem_top.sv
tests/tb_vm_mem_top.sv

//--- Bender.yml
package:
  name: vm_mem

sources:
  - common/vm_pkg.sv
  - common/dmem_if.sv
  - dtlb/dtlb.sv
  - ptw/page_walker.sv
  - hdl/perm_check.sv
  - hdl/data_ram.sv
  - hdl/mem_pipe_ctrl.sv
  - hdl/vm_mem_top.sv
  - target: test
    files:
      - tests/tb_vm_mem_top.sv
